// ==== build.f ====
common/core_map_pkg.sv
common/vita_pkg.sv
rtl/apb_decode.sv
rtl/misc_regs.sv
settings/settings_bus_16le.sv
settings/core_settings.sv
vita/vita_time_64.sv
rtl/readback_mux.sv
rtl/u1_core.sv
sim/tb_u1_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_u1_core
RTL_TOP   ?= u1_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= All checks passed

.DEFAULT_GOAL := sim
.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_u1_core.sv ====
`default_nettype none

module tb_u1_core;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 20;   // cycles or polls allowed per wait

   logic        wb_clk, wb_rst;
   logic [10:0] paddr;
   logic        psel, penable, pwrite;
   logic [15:0] pwdata;
   wire  [15:0] prdata;
   wire         pready, pslverr;
   logic        st_status, st_ld, st_refmon, pps;
   wire  [2:0]  led;
   wire         sync_b, ref_sel;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] rng = 32'h06bccd96;

   // register model behind the reference function
   logic [15:0] leds_m, cgen_m, test_m;
   logic [31:0] test32_m;

   // pending compares, drained by the compare process
   logic [63:0] act_q[$];
   logic [63:0] exp_q[$];
   string       msg_q[$];

   u1_core i_dut
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
      .pwrite_i(pwrite), .pwdata_i(pwdata),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .cgen_st_status_i(st_status), .cgen_st_ld_i(st_ld), .cgen_st_refmon_i(st_refmon),
      .cgen_sync_b_o(sync_b), .cgen_ref_sel_o(ref_sel),
      .pps_i(pps), .led_o(led)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model and helpers

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [10:0] set_addr(input int n, input logic hi);
      return 11'h400 + 11'(4 * n) + (hi ? 11'd2 : 11'd0);   // settings window at slave 8
   endfunction

   function automatic logic [10:0] rb_addr(input int w, input logic hi);
      return 11'h380 + 11'(4 * w) + (hi ? 11'd2 : 11'd0);
   endfunction

   function automatic logic exp_err(input logic [10:0] addr);
      logic [3:0] s;
      s = addr[10:7];
      return !(s == 4'd0 || s == 4'd7 || s == 4'd8 || s == 4'd9);
   endfunction

   // led register bits as wired on the board
   function automatic logic [2:0] board_leds(input logic [15:0] r);
      logic [2:0] l;
      l[2] = r[0];
      l[0] = r[1];
      l[1] = r[2];
      return l;
   endfunction

   // expected read data for any address, time words excluded
   function automatic logic [15:0] ref_read(input logic [10:0] addr);
      logic [6:0]  offs;
      logic [31:0] word;
      offs = addr[6:0];
      word = 32'h0;
      if (addr[10:7] == 4'd0)
      begin
         case (offs)
            7'd0:    return leds_m;
            7'd4:    return cgen_m;
            7'd6:    return {13'h0, st_status, st_ld, st_refmon};
            7'd8:    return test_m;
            7'd16:   return 16'h0003;
            default: return 16'hBEEF;
         endcase
      end
      if (addr[10:7] == 4'd7 && offs[6:2] == 5'd4)
         word = test32_m;
      return offs[1] ? word[31:16] : word[15:0];
   endfunction

   task automatic reset_model();
      leds_m   = 16'h0;
      cgen_m   = 16'h3;   // sync_b and ref_sel idle high
      test_m   = 16'h0;
      test32_m = 32'h0;
   endtask

   task automatic abort_run(input string why);
      $display("ERROR: %s at %0d ns", why, $time);
      $display("%0d checks, %0d errors", checks, errors);
      $display("Checks failed");
      $finish;
   endtask

   task automatic check(input logic [63:0] act, input logic [63:0] exp, input string msg);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("FAILED at %0d ns: %s, got %0h expected %0h", $time, msg, act, exp);
      end
   endtask

   task automatic expect_eq(input logic [63:0] act, input logic [63:0] exp,
                            input string msg);
      act_q.push_back(act);
      exp_q.push_back(exp);
      msg_q.push_back(msg);
   endtask

   always @(negedge wb_clk)
   begin
      while (act_q.size() > 0)
         check(act_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
   end

   ////////////////////////////////////////////////////////////////////////////
   // APB host

   task automatic apb_xfer(input logic wr, input logic [10:0] addr, input logic [15:0] wdata,
                           output logic [15:0] rdata, output logic err);
      int n;
      @(negedge wb_clk);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge wb_clk);
      penable = 1'b1;
      n = 0;
      #1;
      while (!pready && n < TIMEOUT)
      begin
         @(negedge wb_clk);
         #1;
         n++;
      end
      if (!pready)
         abort_run("no pready in the access cycle");
      else
      begin
         rdata = prdata;   // sampled mid access cycle
         err   = pslverr;
         @(negedge wb_clk);
         psel    = 1'b0;
         penable = 1'b0;
         pwrite  = 1'b0;
      end
   endtask

   task automatic apb_write(input logic [10:0] addr, input logic [15:0] data);
      logic [15:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      expect_eq(64'(err), 64'(exp_err(addr)), "pslverr on write");
   endtask

   task automatic apb_read(input logic [10:0] addr, output logic [15:0] rd);
      logic err;
      apb_xfer(1'b0, addr, 16'h0, rd, err);
      expect_eq(64'(err), 64'(exp_err(addr)), "pslverr on read");
   endtask

   task automatic read_check(input logic [10:0] addr, input string msg);
      logic [15:0] rd;
      apb_read(addr, rd);
      expect_eq(64'(rd), 64'(ref_read(addr)), msg);
   endtask

   task automatic misc_write(input logic [6:0] offs, input logic [15:0] data);
      apb_write({4'd0, offs}, data);
      case (offs)
         7'd0:    leds_m = data;
         7'd4:    cgen_m = data;
         7'd8:    test_m = data;
         default: ;
      endcase
   endtask

   // low half first, the high half fires the strobe
   task automatic set_write(input int n, input logic [31:0] data);
      apb_write(set_addr(n, 1'b0), data[15:0]);
      apb_write(set_addr(n, 1'b1), data[31:16]);
      if (n == 52)
         test32_m = data;
      if (n == 50)
         reset_model();
   endtask

   task automatic read32(input int w, output logic [31:0] word);
      logic [15:0] lo, hi;
      apb_read(rb_addr(w, 1'b0), lo);
      apb_read(rb_addr(w, 1'b1), hi);
      word = {hi, lo};
   endtask

   task automatic read64(input int w, output logic [63:0] val);
      logic [31:0] hi, lo;
      read32(w, hi);
      read32(w + 1, lo);
      val = {hi, lo};
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (act_q.size() > 0 && n < TIMEOUT)
      begin
         @(posedge wb_clk);
         n++;
      end
      if (act_q.size() > 0)
         abort_run("compare queue did not drain");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial
   begin
      logic [15:0] rd;
      logic [31:0] v;
      logic [63:0] t, got;
      int          i, n;
      wb_rst    = 1'b1;
      paddr     = 11'h0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = 16'h0;
      st_status = 1'b0;
      st_ld     = 1'b0;
      st_refmon = 1'b0;
      pps       = 1'b0;
      reset_model();
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      // reset values
      read_check(11'h000, "leds after reset");
      expect_eq(64'(led), 64'h0, "led_o after reset");
      expect_eq(64'({sync_b, ref_sel}), 64'h3, "cgen outputs after reset");
      read_check(11'h010, "compat number");
      read_check(11'h002, "unknown misc offset");

      for (i = 0; i < 8; i++)
      begin
         rng = xorshift32(rng);
         misc_write(7'd0, rng[15:0]);
         misc_write(7'd4, rng[31:16]);
         rng = xorshift32(rng);
         misc_write(7'd8, rng[15:0]);
         {st_status, st_ld, st_refmon} = rng[18:16];
         read_check(11'h000, "led register");
         read_check(11'h004, "cgen control register");
         read_check(11'h008, "test register");
         read_check(11'h006, "cgen status");
         expect_eq(64'(led), 64'(board_leds(leds_m)), "led_o bit order");
         expect_eq(64'({sync_b, ref_sel}), 64'(cgen_m[1:0]), "cgen outputs");
      end

      // settings into readback
      rng = xorshift32(rng);
      set_write(52, rng);
      read_check(rb_addr(4, 1'b0), "test32 low half");
      read_check(rb_addr(4, 1'b1), "test32 high half");
      for (i = 5; i < 16; i++)
      begin
         read_check(rb_addr(i, 1'b0), "unused readback word, low");
         read_check(rb_addr(i, 1'b1), "unused readback word, high");
      end

      // time load at pps, high word kept clear of wrap
      rng = xorshift32(rng);
      t[63:32] = (rng & 32'h7fff_ffff) | 32'h1;
      rng = xorshift32(rng);
      t[31:0] = rng;
      set_write(40, t[63:32]);
      set_write(41, t[31:0]);
      set_write(42, 32'h1);
      pps = 1'b1;
      n = 0;
      rd = 16'h0;
      while (rd == 16'h0 && n < TIMEOUT)
      begin
         apb_read(rb_addr(2, 1'b0), rd);   // bit 32 of the load word is set
         n++;
      end
      if (rd == 16'h0)
         abort_run("pps capture never changed");
      pps = 1'b0;
      read64(2, got);
      expect_eq(got, t, "pps capture");
      read32(0, v);
      expect_eq(64'(v >= t[63:32]), 64'h1, "live high word after pps load");

      // immediate load
      rng = xorshift32(rng);
      t = {rng & 32'h7fff_ffff, 32'h0};
      set_write(40, t[63:32]);
      set_write(41, 32'h0);
      set_write(42, 32'h0);
      read64(0, got);
      expect_eq(64'(got >= t && got < t + 64'd1000), 64'h1, "live time after immediate load");

      // unmapped slave 3
      read_check(11'h180, "read of slave 3");
      apb_write(11'h1a0, 16'h1234);

      // soft reset through settings register 50
      misc_write(7'd8, 16'ha5a5);
      set_write(50, 32'h0);
      n = 0;
      rd = 16'hffff;
      while (rd != 16'h0 && n < TIMEOUT)
      begin
         apb_read(11'h008, rd);
         n++;
      end
      if (rd != 16'h0)
         abort_run("test register not cleared by soft reset");
      read_check(11'h000, "leds after soft reset");
      read_check(11'h004, "cgen control after soft reset");
      read_check(rb_addr(4, 1'b0), "test32 low after soft reset");
      read_check(rb_addr(4, 1'b1), "test32 high after soft reset");
      read32(0, v);
      expect_eq(64'(v), 64'h0, "time high word after soft reset");

      wait_drained();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/u1_core.sv ====
`default_nettype none

module u1_core
   import core_map_pkg::*;
   import vita_pkg::*;
#(
   parameter logic [7:0] COMPAT_NUM = 8'd3,
   parameter set_addr_t  TIME_BASE  = SR_TIME64,
   parameter set_addr_t  RST_BASE   = SR_GLOBAL_RESET,
   parameter set_addr_t  TEST_BASE  = SR_REG_TEST32
)
(
   input  wire                wb_clk,
   input  wire                wb_rst,
   // APB host port
   input  wire [ADDR_W-1:0]   paddr_i,
   input  wire                psel_i,
   input  wire                penable_i,
   input  wire                pwrite_i,
   input  wire [DATA_W-1:0]   pwdata_i,
   output logic [DATA_W-1:0]  prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   // clock generator
   input  wire                cgen_st_status_i,
   input  wire                cgen_st_ld_i,
   input  wire                cgen_st_refmon_i,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o,
   input  wire                pps_i,
   output logic [2:0]         led_o
);

   logic               core_rst;
   logic               misc_wr, set_wr;
   logic [OFFS_W-1:0]  offs;
   logic [DATA_W-1:0]  wdata, misc_rdata, rb_rdata;
   logic               set_stb;
   set_addr_t          set_addr;
   set_data_t          set_data, test32;
   vita_time_t         vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // host side

   apb_decode u_decode
   (
      .wb_clk(wb_clk), .core_rst_i(core_rst),
      .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
      .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
      .misc_rdata_i(misc_rdata), .rb_rdata_i(rb_rdata),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
      .misc_wr_o(misc_wr), .set_wr_o(set_wr), .offs_o(offs), .wdata_o(wdata)
   );

   misc_regs #(.COMPAT_NUM(COMPAT_NUM)) u_misc
   (
      .wb_clk(wb_clk), .core_rst_i(core_rst),
      .wr_i(misc_wr), .offs_i(offs), .wdata_i(wdata), .rdata_o(misc_rdata),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .led_o(led_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o)
   );

   settings_bus_16le u_set_bus
   (
      .wb_clk(wb_clk), .core_rst_i(core_rst),
      .wr_i(set_wr), .paddr_i(paddr_i[SET_AW-1:0]), .wdata_i(wdata),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   readback_mux u_readback
   (
      .offs_i(offs), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .test32_i(test32), .rdata_o(rb_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // settings bus users

   core_settings #(.RST_ADDR(RST_BASE), .TEST_ADDR(TEST_BASE)) u_core_set
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .core_rst_o(core_rst), .test32_o(test32)
   );

   vita_time_64 #(.BASE(TIME_BASE)) u_time
   (
      .wb_clk(wb_clk), .core_rst_i(core_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

endmodule

`default_nettype wire

// ==== rtl/readback_mux.sv ====
`default_nettype none

module readback_mux
   import core_map_pkg::*;
   import vita_pkg::*;
(
   input  wire [OFFS_W-1:0]   offs_i,
   input  vita_time_t         vita_time_i,
   input  vita_time_t         vita_time_pps_i,
   input  set_data_t          test32_i,
   output logic [DATA_W-1:0]  rdata_o
);

   set_data_t word;

   always_comb
   begin
      word = '0;
      if (!offs_i[6])   // only 16 words exist
      begin
         case (offs_i[5:2])
            RB_TIME_HI: word = vita_time_i[63:32];
            RB_TIME_LO: word = vita_time_i[31:0];
            RB_PPS_HI:  word = vita_time_pps_i[63:32];
            RB_PPS_LO:  word = vita_time_pps_i[31:0];
            RB_TEST32:  word = test32_i;
            default:    word = '0;
         endcase
      end
   end

   // little endian halves
   assign rdata_o = offs_i[1] ? word[31:16] : word[15:0];

endmodule

`default_nettype wire

// ==== vita/vita_time_64.sv ====
`default_nettype none

module vita_time_64
   import core_map_pkg::*;
   import vita_pkg::*;
#(
   parameter set_addr_t BASE = SR_TIME64
)
(
   input  wire        wb_clk,
   input  wire        core_rst_i,
   input  wire        set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  wire        pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);

   localparam set_addr_t ADDR_HI   = set_addr_t'(BASE + TIME_HI_OFS);
   localparam set_addr_t ADDR_LO   = set_addr_t'(BASE + TIME_LO_OFS);
   localparam set_addr_t ADDR_CTRL = set_addr_t'(BASE + TIME_CTRL_OFS);

   logic [2:0] pps_q;          // two sync stages, third for the edge
   logic       pps_edge;
   logic       pps_pend_q;     // load armed for next pps
   logic       ctrl_wr, load_now;
   set_data_t  time_hi_q, time_lo_q;
   vita_time_t next_time;

   assign pps_edge = pps_q[1] & ~pps_q[2];
   assign ctrl_wr  = set_stb_i && (set_addr_i == ADDR_CTRL);
   assign load_now = ctrl_wr & ~set_data_i[TCTRL_AT_PPS];

   always_comb
   begin
      if (load_now || (pps_edge && pps_pend_q))
         next_time = {time_hi_q, time_lo_q};
      else
         next_time = vita_time_o + 64'd1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // load words, pending mode, counter and pps capture

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         pps_q           <= '0;
         pps_pend_q      <= 1'b0;
         time_hi_q       <= '0;
         time_lo_q       <= '0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_q <= {pps_q[1:0], pps_i};
         if (set_stb_i && (set_addr_i == ADDR_HI))
            time_hi_q <= set_data_i;
         if (set_stb_i && (set_addr_i == ADDR_LO))
            time_lo_q <= set_data_i;
         if (ctrl_wr)
            pps_pend_q <= set_data_i[TCTRL_AT_PPS];
         else if (pps_edge)
            pps_pend_q <= 1'b0;
         vita_time_o <= next_time;
         if (pps_edge)
            vita_time_pps_o <= next_time;   // value the counter takes now
      end
   end

endmodule

`default_nettype wire

// ==== settings/core_settings.sv ====
`default_nettype none

module core_settings
   import core_map_pkg::*;
#(
   parameter set_addr_t RST_ADDR  = SR_GLOBAL_RESET,
   parameter set_addr_t TEST_ADDR = SR_REG_TEST32
)
(
   input  wire        wb_clk,
   input  wire        wb_rst,
   input  wire        set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   output logic       core_rst_o,
   output set_data_t  test32_o
);

   logic rst_req_q, soft_rst_q;

   // soft reset pulse, two cycles behind the strobe, data ignored
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         rst_req_q  <= 1'b0;
         soft_rst_q <= 1'b0;
      end
      else
      begin
         rst_req_q  <= set_stb_i && (set_addr_i == RST_ADDR);
         soft_rst_q <= rst_req_q;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      core_rst_o <= wb_rst | soft_rst_q;
   end

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_o)
         test32_o <= '0;
      else if (set_stb_i && (set_addr_i == TEST_ADDR))
         test32_o <= set_data_i;
   end

endmodule

`default_nettype wire

// ==== settings/settings_bus_16le.sv ====
`default_nettype none

module settings_bus_16le
   import core_map_pkg::*;
(
   input  wire                wb_clk,
   input  wire                core_rst_i,
   input  wire                wr_i,
   input  wire [SET_AW-1:0]   paddr_i,
   input  wire [DATA_W-1:0]   wdata_i,
   output logic               set_stb_o,
   output set_addr_t          set_addr_o,
   output set_data_t          set_data_o
);

   logic [DATA_W-1:0] low_q;   // low half waiting for its partner
   logic              hi_half;

   assign hi_half = paddr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         set_stb_o  <= 1'b0;
         set_addr_o <= '0;
         set_data_o <= '0;
         low_q      <= '0;
      end
      else
      begin
         set_stb_o <= wr_i & hi_half;   // fires on the high half only
         if (wr_i && !hi_half)
            low_q <= wdata_i;
         if (wr_i && hi_half)
         begin
            set_addr_o <= set_addr_t'(paddr_i[SET_AW-1:2]);
            set_data_o <= {wdata_i, low_q};
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/misc_regs.sv ====
`default_nettype none

module misc_regs
   import core_map_pkg::*;
#(
   parameter logic [7:0] COMPAT_NUM = 8'd3
)
(
   input  wire                wb_clk,
   input  wire                core_rst_i,
   input  wire                wr_i,
   input  wire [OFFS_W-1:0]   offs_i,
   input  wire [DATA_W-1:0]   wdata_i,
   output logic [DATA_W-1:0]  rdata_o,
   input  wire                cgen_st_status_i,
   input  wire                cgen_st_ld_i,
   input  wire                cgen_st_refmon_i,
   output logic [2:0]         led_o,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o
);

   logic [DATA_W-1:0] reg_leds, reg_cgen_ctrl, reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (core_rst_i)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'd3;   // sync_b and ref_sel idle high
         reg_test      <= '0;
      end
      else if (wr_i)
      begin
         case (offs_i)
            REG_LEDS:      reg_leds      <= wdata_i;
            REG_CGEN_CTRL: reg_cgen_ctrl <= wdata_i;
            REG_TEST:      reg_test      <= wdata_i;
            default:       ;
         endcase
      end
   end

   // board wiring of the leds
   assign led_o = {reg_leds[0], reg_leds[2], reg_leds[1]};
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];

   always_comb
   begin
      case (offs_i)
         REG_LEDS:      rdata_o = reg_leds;
         REG_CGEN_CTRL: rdata_o = reg_cgen_ctrl;
         REG_CGEN_ST:   rdata_o = {{(DATA_W-3){1'b0}}, cgen_st_status_i,
                                   cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      rdata_o = reg_test;
         REG_COMPAT:    rdata_o = {{(DATA_W-8){1'b0}}, COMPAT_NUM};
         default:       rdata_o = MISC_DEFAULT_RD;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/apb_decode.sv ====
`default_nettype none

module apb_decode
   import core_map_pkg::*;
(
   input  wire                wb_clk,
   input  wire                core_rst_i,
   input  wire [ADDR_W-1:0]   paddr_i,
   input  wire                psel_i,
   input  wire                penable_i,
   input  wire                pwrite_i,
   input  wire [DATA_W-1:0]   pwdata_i,
   input  wire [DATA_W-1:0]   misc_rdata_i,
   input  wire [DATA_W-1:0]   rb_rdata_i,
   output logic [DATA_W-1:0]  prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   output logic               misc_wr_o,
   output logic               set_wr_o,
   output logic [OFFS_W-1:0]  offs_o,
   output logic [DATA_W-1:0]  wdata_o
);

   localparam logic [SLAVE_W-1:0] SET_MASK = 4'hE;   // settings spans 8 and 9

   logic [SLAVE_W-1:0] slave;
   logic access, wr_ok, setup_q;
   logic hit_misc, hit_rb, hit_set;

   // follows the APB setup phase, so a write needs a proper setup cycle
   always_ff @(posedge wb_clk)
   begin
      setup_q <= psel_i & ~penable_i;
   end

   assign slave    = paddr_i[ADDR_W-1 -: SLAVE_W];
   assign hit_misc = (slave == SL_MISC);
   assign hit_rb   = (slave == SL_READBACK);
   assign hit_set  = ((slave & SET_MASK) == SL_SETTINGS);

   assign access    = psel_i & penable_i;
   assign wr_ok     = access & pwrite_i & setup_q & ~core_rst_i;
   assign pready_o  = access;                                  // no wait states
   assign pslverr_o = access & ~(hit_misc | hit_rb | hit_set);

   assign misc_wr_o = wr_ok & hit_misc;
   assign set_wr_o  = wr_ok & hit_set;
   assign offs_o    = paddr_i[OFFS_W-1:0];
   assign wdata_o   = pwdata_i;

   always_comb
   begin
      if (hit_misc)
         prdata_o = misc_rdata_i;
      else if (hit_rb)
         prdata_o = rb_rdata_i;
      else
         prdata_o = '0;   // settings is write only, unmapped reads 0
   end

endmodule

`default_nettype wire

// ==== common/vita_pkg.sv ====
`default_nettype none

package vita_pkg;

   typedef logic [63:0] vita_time_t;

   // time register offsets from the counter base
   localparam int TIME_HI_OFS   = 0;
   localparam int TIME_LO_OFS   = 1;
   localparam int TIME_CTRL_OFS = 2;

   localparam int TCTRL_AT_PPS  = 0;   // load waits for next pps edge

   // 32-bit readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;

endpackage

`default_nettype wire

// ==== common/core_map_pkg.sv ====
`default_nettype none

package core_map_pkg;

   // APB host port
   localparam int DATA_W  = 16;
   localparam int ADDR_W  = 11;
   localparam int SLAVE_W = 4;                  // paddr[10:7], 128 bytes per slave
   localparam int OFFS_W  = ADDR_W - SLAVE_W;   // byte offset inside a slave

   // slave indices
   localparam logic [SLAVE_W-1:0] SL_MISC     = 4'd0;
   localparam logic [SLAVE_W-1:0] SL_READBACK = 4'd7;
   localparam logic [SLAVE_W-1:0] SL_SETTINGS = 4'd8;  // 8 and 9, double wide

   // misc register byte offsets
   localparam logic [OFFS_W-1:0] REG_LEDS      = 7'd0;
   localparam logic [OFFS_W-1:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [OFFS_W-1:0] REG_CGEN_ST   = 7'd6;   // read only
   localparam logic [OFFS_W-1:0] REG_TEST      = 7'd8;
   localparam logic [OFFS_W-1:0] REG_COMPAT    = 7'd16;  // read only

   localparam logic [DATA_W-1:0] MISC_DEFAULT_RD = 16'hBEEF;

   // settings bus
   localparam int SET_AW = 8;

   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [31:0]       set_data_t;

   localparam set_addr_t SR_TIME64       = 8'd40;   // 3 regs
   localparam set_addr_t SR_GLOBAL_RESET = 8'd50;
   localparam set_addr_t SR_REG_TEST32   = 8'd52;

endpackage

`default_nettype wire
